//--- hw/mem_req_pkg.sv
/*
 * memory-test request generator, shared definitions
 * command word layout, AXI request and write-beat structs,
 * bus widths and the request FSM state encoding
 */

package mem_req_pkg;

  // ==============================
  // bus widths
  // ==============================
  localparam int addr_w = 40;
  localparam int id_w   = 14;
  localparam int data_w = 256;
  localparam int strb_w = 32;
  localparam int user_w = 26;
  localparam int dly_w  = 8;
  localparam int pend_w = 9;

  // ==============================
  // test command, 128 bits, msb first
  // ==============================
  typedef struct packed {
    logic [3:0]        region;
    logic [3:0]        qos;
    logic [1:0]        lock;
    logic [2:0]        prot;
    logic [3:0]        cache;
    logic [2:0]        size;
    logic [1:0]        burst;
    logic [user_w-1:0] user;
    logic [7:0]        len;
    logic [addr_w-1:0] addr;
    // delay from retire of previous cmd to first w beat
    logic [dly_w-1:0]  wdata_dly;
    // delay from retire of previous cmd to this request
    logic [dly_w-1:0]  gap_dly;
    logic              is_read;
    // former dual-command bit, ignored
    logic              reserved;
    logic [id_w-1:0]   id;
  } mem_cmd_t;

  // AR / AW request fields
  typedef struct packed {
    logic [id_w-1:0]   id;
    logic [addr_w-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
    logic [user_w-1:0] user;
    logic [3:0]        cache;
    logic [2:0]        prot;
    logic [1:0]        lock;
    logic [3:0]        qos;
    logic [3:0]        region;
  } axi_ax_t;

  // one W beat
  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
  } axi_w_t;

  // request FSM states
  typedef enum logic [1:0] {
    idle  = 2'd0,
    issue = 2'd1,
    wdata = 2'd2
  } req_state_e;

endpackage

//--- hw/cmd_fetch.sv
/*
 * command fetch side of the request generator
 * keeps the delay settings of the last retired command and
 * times the gap and write-data delays for the next one
 */

`timescale 1ns/1ps

module cmd_fetch (
  input  logic                  axi_clk,
  input  logic                  axi_rstn,
  input  logic                  run,
  input  logic                  cmd_next,
  input  mem_req_pkg::mem_cmd_t cmd,
  output logic                  gap_done,
  output logic                  wdata_dly_done
);

  import mem_req_pkg::*;

  logic [dly_w-1:0] gap_set;
  logic [dly_w-1:0] wdly_set;
  logic [dly_w-1:0] gap_cnt;
  logic [dly_w-1:0] wdly_cnt;

  // delays travel with the retiring command, apply to the next one
  always_ff @(posedge axi_clk or negedge axi_rstn) begin
    if (!axi_rstn) begin
      gap_set  <= '0;
      wdly_set <= '0;
    end else if (cmd_next) begin
      gap_set  <= cmd.gap_dly;
      wdly_set <= cmd.wdata_dly;
    end
  end

  // ==============================
  // saturating delay counters
  // ==============================
  always_ff @(posedge axi_clk or negedge axi_rstn) begin
    if (!axi_rstn) begin
      gap_cnt  <= '0;
      wdly_cnt <= '0;
    end else if (!run || cmd_next) begin
      gap_cnt  <= '0;
      wdly_cnt <= '0;
    end else begin
      if (gap_cnt != '1) begin
        gap_cnt <= gap_cnt + 1'b1;
      end
      if (wdly_cnt != '1) begin
        wdly_cnt <= wdly_cnt + 1'b1;
      end
    end
  end

  assign gap_done       = (gap_cnt >= gap_set);
  assign wdata_dly_done = (wdly_cnt >= wdly_set);

endmodule

//--- hw/req_sequencer.sv
/*
 * request sequencer
 * three-state FSM that drives AR, AW and W valids for the
 * current command, counts W beats, raises wlast and pulses
 * cmd_next when the command is fully accepted
 */

`timescale 1ns/1ps

module req_sequencer (
  input  logic                           axi_clk,
  input  logic                           axi_rstn,
  input  logic                           run,
  input  mem_req_pkg::mem_cmd_t          cmd,
  input  logic                           gap_done,
  input  logic                           wdata_dly_done,
  input  logic                           rd_wait,
  input  logic [mem_req_pkg::pend_w-1:0] ar_pend_cnt,
  input  logic [mem_req_pkg::pend_w-1:0] aw_pend_cnt,
  input  logic [7:0]                     pend_max,
  input  logic                           arready,
  input  logic                           awready,
  input  logic                           wready,
  output logic                           arvalid,
  output logic                           awvalid,
  output logic                           wvalid,
  output logic                           wlast,
  output logic                           cmd_next
);

  import mem_req_pkg::*;

  req_state_e state;
  req_state_e state_nxt;

  // aw accepted for the current command
  logic       aw_done;
  // W beats accepted so far, one wider than len
  logic [8:0] beat_cnt;
  logic [8:0] len_ext;

  logic       ar_fire;
  logic       aw_fire;
  logic       w_fire;
  logic       beats_left;
  logic       burst_done;
  logic       wr_retire;
  logic       ar_room;
  logic       aw_room;

  assign len_ext    = {1'b0, cmd.len};
  assign beats_left = (beat_cnt <= len_ext);
  assign ar_room    = (ar_pend_cnt < pend_w'(pend_max));
  assign aw_room    = (aw_pend_cnt < pend_w'(pend_max));

  // ==============================
  // valids and last
  // ==============================
  assign arvalid = (state == issue) & cmd.is_read & gap_done & !rd_wait & ar_room;
  assign awvalid = (state == issue) & !cmd.is_read & !aw_done & gap_done & aw_room;
  // W beats may run ahead of AW
  assign wvalid  = (state != idle) & !cmd.is_read & gap_done & wdata_dly_done & beats_left;
  assign wlast   = !cmd.is_read & (beat_cnt == len_ext);

  assign ar_fire = arvalid & arready;
  assign aw_fire = awvalid & awready;
  assign w_fire  = wvalid & wready;

  // burst is over when wlast goes now or went earlier
  assign burst_done = (w_fire & wlast) | !beats_left;
  assign wr_retire  = !cmd.is_read & (aw_fire | aw_done) & burst_done;
  assign cmd_next   = (state != idle) & (cmd.is_read ? ar_fire : wr_retire);

  // ==============================
  // FSM
  // ==============================
  always_comb begin
    state_nxt = state;
    case (state)
      idle: begin
        if (run) begin
          state_nxt = issue;
        end
      end
      issue: begin
        if (!run) begin
          state_nxt = idle;
        end else if (aw_fire && !wr_retire) begin
          state_nxt = wdata;
        end
      end
      wdata: begin
        if (!run) begin
          state_nxt = idle;
        end else if (wr_retire) begin
          state_nxt = issue;
        end
      end
      default: state_nxt = idle;
    endcase
  end

  always_ff @(posedge axi_clk or negedge axi_rstn) begin
    if (!axi_rstn) begin
      state <= idle;
    end else begin
      state <= state_nxt;
    end
  end

  // progress of the current write, kept across a stop
  always_ff @(posedge axi_clk or negedge axi_rstn) begin
    if (!axi_rstn) begin
      aw_done  <= 1'b0;
      beat_cnt <= '0;
    end else if (cmd_next) begin
      aw_done  <= 1'b0;
      beat_cnt <= '0;
    end else begin
      if (aw_fire) begin
        aw_done <= 1'b1;
      end
      if (w_fire) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

endmodule

//--- hw/req_stats.sv
/*
 * request statistics
 * counts retired commands, AR transfers, completed write
 * bursts and accepted W beats, with a synchronous clear
 */

`timescale 1ns/1ps

module req_stats #(
  parameter int cnt_w = 24
) (
  input  logic               axi_clk,
  input  logic               axi_rstn,
  input  logic               stats_clear,
  input  logic               cmd_next,
  input  logic               arvalid,
  input  logic               arready,
  input  logic               wvalid,
  input  logic               wready,
  input  logic               wlast,
  output logic [cnt_w-1:0]   req_cnt,
  output logic [cnt_w-1:0]   rd_cnt,
  output logic [cnt_w-1:0]   wr_cnt,
  output logic [cnt_w+7:0]   wbeat_cnt
);

  logic ar_fire;
  logic w_fire;

  assign ar_fire = arvalid & arready;
  assign w_fire  = wvalid & wready;

  // ==============================
  // counters
  // ==============================
  // clear wins over a same-cycle event
  always_ff @(posedge axi_clk or negedge axi_rstn) begin
    if (!axi_rstn) begin
      req_cnt   <= '0;
      rd_cnt    <= '0;
      wr_cnt    <= '0;
      wbeat_cnt <= '0;
    end else if (stats_clear) begin
      req_cnt   <= '0;
      rd_cnt    <= '0;
      wr_cnt    <= '0;
      wbeat_cnt <= '0;
    end else begin
      if (cmd_next) begin
        req_cnt <= req_cnt + 1'b1;
      end
      if (ar_fire) begin
        rd_cnt <= rd_cnt + 1'b1;
      end
      // one per finished burst
      if (w_fire && wlast) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      if (w_fire) begin
        wbeat_cnt <= wbeat_cnt + 1'b1;
      end
    end
  end

endmodule

//--- hw/mem_req_gen.sv
/*
 * memory-test AXI request generator, top level
 * turns test commands into AR requests or AW requests with
 * W bursts, and keeps request statistics
 */

`timescale 1ns/1ps

module mem_req_gen #(
  parameter int cnt_w = 24
) (
  input  logic                           axi_clk,
  input  logic                           axi_rstn,
  input  logic                           run,
  input  logic                           rd_wait,
  input  logic                           stats_clear,
  input  mem_req_pkg::mem_cmd_t          cmd,
  input  logic [mem_req_pkg::data_w-1:0] wdata,
  input  logic [mem_req_pkg::strb_w-1:0] wstrb,
  input  logic [mem_req_pkg::pend_w-1:0] ar_pend_cnt,
  input  logic [mem_req_pkg::pend_w-1:0] aw_pend_cnt,
  input  logic [7:0]                     pend_max,
  output logic                           cmd_next,
  output mem_req_pkg::axi_ax_t           ar,
  output mem_req_pkg::axi_ax_t           aw,
  output logic                           arvalid,
  output logic                           awvalid,
  input  logic                           arready,
  input  logic                           awready,
  output mem_req_pkg::axi_w_t            w,
  output logic                           wvalid,
  input  logic                           wready,
  output logic [cnt_w-1:0]               req_cnt,
  output logic [cnt_w-1:0]               rd_cnt,
  output logic [cnt_w-1:0]               wr_cnt,
  output logic [cnt_w+7:0]               wbeat_cnt
);

  import mem_req_pkg::*;

  logic    gap_done;
  logic    wdata_dly_done;
  logic    wlast;
  axi_ax_t cmd_ax;

  // ==============================
  // channel packing
  // ==============================
  assign cmd_ax = '{id: cmd.id, addr: cmd.addr, len: cmd.len, size: cmd.size,
                    burst: cmd.burst, user: cmd.user, cache: cmd.cache,
                    prot: cmd.prot, lock: cmd.lock, qos: cmd.qos, region: cmd.region};

  // the idle channel shows zeros
  assign ar = cmd.is_read ? cmd_ax : '0;
  assign aw = cmd.is_read ? '0 : cmd_ax;
  assign w  = '{data: wdata, strb: wstrb, last: wlast};

  cmd_fetch u_cmd_fetch (
    .axi_clk        (axi_clk),
    .axi_rstn       (axi_rstn),
    .run            (run),
    .cmd_next       (cmd_next),
    .cmd            (cmd),
    .gap_done       (gap_done),
    .wdata_dly_done (wdata_dly_done)
  );

  req_sequencer u_req_sequencer (
    .axi_clk        (axi_clk),
    .axi_rstn       (axi_rstn),
    .run            (run),
    .cmd            (cmd),
    .gap_done       (gap_done),
    .wdata_dly_done (wdata_dly_done),
    .rd_wait        (rd_wait),
    .ar_pend_cnt    (ar_pend_cnt),
    .aw_pend_cnt    (aw_pend_cnt),
    .pend_max       (pend_max),
    .arready        (arready),
    .awready        (awready),
    .wready         (wready),
    .arvalid        (arvalid),
    .awvalid        (awvalid),
    .wvalid         (wvalid),
    .wlast          (wlast),
    .cmd_next       (cmd_next)
  );

  req_stats #(
    .cnt_w (cnt_w)
  ) u_req_stats (
    .axi_clk     (axi_clk),
    .axi_rstn    (axi_rstn),
    .stats_clear (stats_clear),
    .cmd_next    (cmd_next),
    .arvalid     (arvalid),
    .arready     (arready),
    .wvalid      (wvalid),
    .wready      (wready),
    .wlast       (wlast),
    .req_cnt     (req_cnt),
    .rd_cnt      (rd_cnt),
    .wr_cnt      (wr_cnt),
    .wbeat_cnt   (wbeat_cnt)
  );

endmodule

//--- include/tb_cmd_table.svh
/*
 * command table for the request generator testbench
 * ten test commands with their expected W beat counts
 */

`ifndef TB_CMD_TABLE_SVH
`define TB_CMD_TABLE_SVH

localparam int n_cmds = 10;

mem_cmd_t tbl_cmd [n_cmds];
int       tbl_beats [n_cmds];

// reads and writes, len 0, 1 and 3, small gaps
// the last entry has no gap so the delays are already done while run is low
task automatic load_table();
  //        idx rd    len   gap   wdly  addr              id        beats
  put_entry(0,  1'b1, 8'd0, 8'd2, 8'd0, 40'h00_1000_0040, 14'h0101, 0);
  put_entry(1,  1'b0, 8'd0, 8'd0, 8'd1, 40'h00_1000_0100, 14'h0212, 1);
  put_entry(2,  1'b0, 8'd1, 8'd1, 8'd0, 40'h00_2000_0200, 14'h0323, 2);
  put_entry(3,  1'b1, 8'd3, 8'd0, 8'd0, 40'h01_0000_0800, 14'h0434, 0);
  put_entry(4,  1'b0, 8'd3, 8'd3, 8'd2, 40'h01_0000_1000, 14'h0545, 4);
  put_entry(5,  1'b1, 8'd1, 8'd1, 8'd3, 40'h7f_0000_0040, 14'h1656, 0);
  put_entry(6,  1'b0, 8'd1, 8'd0, 8'd4, 40'h7f_0000_0080, 14'h2767, 2);
  put_entry(7,  1'b1, 8'd0, 8'd0, 8'd0, 40'h00_0000_0000, 14'h3878, 0);
  put_entry(8,  1'b0, 8'd3, 8'd2, 8'd1, 40'hff_ffff_f000, 14'h3fff, 4);
  put_entry(9,  1'b1, 8'd0, 8'd0, 8'd0, 40'h12_3456_7890, 14'h0000, 0);
endtask

`endif

//--- dv/tb_mem_req_gen.sv
/*
 * testbench for the memory-test AXI request generator
 * walks a command table with and without back-pressure and
 * checks AR, AW and W transfers, holds, stop and statistics
 */

`timescale 1ns/1ps

module tb_mem_req_gen;

  import mem_req_pkg::*;

  localparam int cnt_w    = 24;
  localparam int wide_w   = cnt_w + 8;
  localparam int hold_len = 6;
  localparam logic [7:0] pend_lim = 8'd8;

  logic              axi_clk;
  logic              axi_rstn;
  logic              run;
  logic              rd_wait;
  logic              stats_clear;
  mem_cmd_t          cmd;
  logic [data_w-1:0] wdata;
  logic [strb_w-1:0] wstrb;
  logic [pend_w-1:0] ar_pend_cnt;
  logic [pend_w-1:0] aw_pend_cnt;
  logic [7:0]        pend_max;
  logic              cmd_next;
  axi_ax_t           ar;
  axi_ax_t           aw;
  logic              arvalid;
  logic              awvalid;
  logic              arready;
  logic              awready;
  axi_w_t            w;
  logic              wvalid;
  logic              wready;
  logic [cnt_w-1:0]  req_cnt;
  logic [cnt_w-1:0]  rd_cnt;
  logic [cnt_w-1:0]  wr_cnt;
  logic [wide_w-1:0] wbeat_cnt;

  `include "tb_cmd_table.svh"

  // walk state
  int      cur;
  int      wbeat;
  int      hold_left;
  int      rdy_mode;
  int      pass_cyc;
  int      cyc_limit;
  int      err_cnt;
  int      tests_run;
  int      tests_failed;
  bit      run_en;
  bit      bp_en;
  bit      blk_en;
  bit      blocking;
  bit      stop_chk;
  bit      clear_req;
  bit      next_seen;
  // previous sample for the hold checks
  bit      p_run;
  bit      p_arvalid;
  bit      p_arready;
  bit      p_awvalid;
  bit      p_awready;
  bit      p_wvalid;
  bit      p_wready;
  axi_ax_t p_ar;
  axi_ax_t p_aw;
  axi_w_t  p_w;
  // transfers seen for the current entry
  axi_ax_t ar_q[$];
  axi_ax_t aw_q[$];
  axi_w_t  w_q[$];

  mem_req_gen #(.cnt_w(cnt_w)) DUT (.*);

  initial begin
    axi_clk = 1'b0;
    forever begin
      #10 axi_clk = ~axi_clk;
    end
  end

  // cycle budget of the running test
  initial begin
    wait (cyc_limit > 0 && pass_cyc > cyc_limit);
    $display("no cmd_next before timeout, stuck at entry %0d", cur);
    $display("Regression failed");
    $finish;
  end

  // ==============================
  // table helpers and expectations
  // ==============================
  task automatic put_entry(input int i, input logic rd, input logic [7:0] len,
                           input logic [dly_w-1:0] gap, input logic [dly_w-1:0] wdly,
                           input logic [addr_w-1:0] addr, input logic [id_w-1:0] id,
                           input int beats);
    // side fields follow the id so every entry differs
    tbl_cmd[i] = '{region: id[3:0], qos: id[7:4], lock: id[1:0], prot: id[2:0],
                   cache: ~id[3:0], size: 3'd5, burst: 2'b01, user: {id, 12'ha5c},
                   len: len, addr: addr, wdata_dly: wdly, gap_dly: gap, is_read: rd,
                   reserved: id[0], id: id};
    tbl_beats[i] = beats;
  endtask

  function automatic logic [data_w-1:0] beat_data(input int i, input int b);
    logic [31:0] lane;
    lane = {8'(i), 8'(b), 16'(16'h5a00 + i * 16 + b)};
    return {lane, ~lane, lane ^ 32'h0f0f_0f0f, lane, ~lane, lane, lane + 32'd1, lane};
  endfunction

  function automatic logic [strb_w-1:0] beat_strb(input int i, input int b);
    return {8'(b), 8'(i), 16'hf0f0};
  endfunction

  function automatic axi_ax_t expect_ax(input int i);
    mem_cmd_t c;
    c = tbl_cmd[i];
    return '{id: c.id, addr: c.addr, len: c.len, size: c.size, burst: c.burst,
             user: c.user, cache: c.cache, prot: c.prot, lock: c.lock, qos: c.qos,
             region: c.region};
  endfunction

  function automatic axi_w_t expect_w(input int i, input int b);
    return '{data: beat_data(i, b), strb: beat_strb(i, b), last: (b == tbl_beats[i] - 1)};
  endfunction

  // per pass, four times the nominal length of the table
  function automatic int calc_limit();
    int sum;
    sum = 0;
    for (int i = 0; i < n_cmds; i++) begin
      sum += int'(tbl_cmd[i].len) + 1 + int'(tbl_cmd[i].gap_dly)
             + int'(tbl_cmd[i].wdata_dly) + 4;
    end
    return 4 * sum + 100;
  endfunction

  function automatic logic pick_ready();
    if (rdy_mode == 2) begin
      return ($urandom_range(3) != 0);
    end
    return (rdy_mode == 1);
  endfunction

  // ==============================
  // compare tasks
  // ==============================
  task automatic fail_msg(input string text);
    err_cnt++;
    $display("%s", text);
  endtask

  task automatic check_ax(input string name, input axi_ax_t got, input axi_ax_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_w(input string name, input axi_w_t got, input axi_w_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_cnt(input string name, input logic [wide_w-1:0] got,
                           input logic [wide_w-1:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // all transfers of the retired entry, in order
  task automatic check_entry(input int i);
    string tag;
    int    n_ar;
    int    n_w;
    tag  = $sformatf("entry %0d", i);
    n_ar = tbl_cmd[i].is_read ? 1 : 0;
    n_w  = tbl_cmd[i].is_read ? 0 : tbl_beats[i];
    if (ar_q.size() != n_ar || aw_q.size() != 1 - n_ar || w_q.size() != n_w) begin
      fail_msg($sformatf("%s retired after %0d AR, %0d AW and %0d W transfers", tag,
                         ar_q.size(), aw_q.size(), w_q.size()));
    end else if (n_ar == 1) begin
      check_ax({tag, " ar"}, ar_q[0], expect_ax(i));
    end else begin
      check_ax({tag, " aw"}, aw_q[0], expect_ax(i));
      for (int b = 0; b < n_w; b++) begin
        check_w($sformatf("%s w beat %0d", tag, b), w_q[b], expect_w(i, b));
      end
    end
    ar_q.delete();
    aw_q.delete();
    w_q.delete();
  endtask

  // ==============================
  // one clock cycle
  // ==============================
  task automatic sample_outputs();
    if (arvalid && arready) begin
      ar_q.push_back(ar);
    end
    if (awvalid && awready) begin
      aw_q.push_back(aw);
    end
    if (wvalid && wready) begin
      w_q.push_back(w);
      wbeat++;
    end
    if (bp_en && run_en && p_run) begin
      if (p_arvalid && !p_arready && !(arvalid && ar == p_ar)) begin
        fail_msg("arvalid or ar changed before its transfer");
      end
      if (p_awvalid && !p_awready && !(awvalid && aw == p_aw)) begin
        fail_msg("awvalid or aw changed before its transfer");
      end
      if (p_wvalid && !p_wready && !(wvalid && w == p_w)) begin
        fail_msg("wvalid or w changed before its transfer");
      end
    end
    if (blocking && cur < n_cmds) begin
      if (tbl_cmd[cur].is_read && arvalid) begin
        fail_msg("arvalid high while the read is held");
      end
      if (!tbl_cmd[cur].is_read && awvalid) begin
        fail_msg("awvalid high at the pending limit");
      end
    end
    if (stop_chk && (arvalid || awvalid || wvalid || cmd_next)) begin
      fail_msg("request activity while run is low");
    end
    if (cmd_next) begin
      if (cur < n_cmds) begin
        check_entry(cur);
      end else begin
        fail_msg("cmd_next with no command pending");
      end
    end
    next_seen = cmd_next;
    p_run     = run_en;
    p_arvalid = arvalid;
    p_arready = arready;
    p_awvalid = awvalid;
    p_awready = awready;
    p_wvalid  = wvalid;
    p_wready  = wready;
    p_ar      = ar;
    p_aw      = aw;
    p_w       = w;
    pass_cyc++;
  endtask

  task automatic cycle_step();
    logic rd;
    @(negedge axi_clk);
    if (next_seen) begin
      cur++;
      wbeat     = 0;
      hold_left = blk_en ? hold_len : 0;
      if (cur == n_cmds) begin
        run_en   = 1'b0;
        rdy_mode = 0;
      end
    end
    rd          = (cur < n_cmds) ? tbl_cmd[cur].is_read : 1'b0;
    blocking    = (hold_left > 0);
    run         = run_en;
    cmd         = (cur < n_cmds) ? tbl_cmd[cur] : '0;
    wdata       = beat_data(cur, wbeat);
    wstrb       = beat_strb(cur, wbeat);
    // even reads held by rd_wait, odd reads by the AR limit
    rd_wait     = blocking && rd && !cur[0];
    ar_pend_cnt = (blocking && rd && cur[0]) ? pend_w'(pend_lim) : pend_w'(pend_lim - 1);
    aw_pend_cnt = (blocking && !rd) ? pend_w'(pend_lim) : pend_w'(pend_lim - 1);
    stats_clear = clear_req;
    clear_req   = 1'b0;
    arready     = pick_ready();
    awready     = pick_ready();
    wready      = pick_ready();
    if (hold_left > 0) begin
      hold_left--;
    end
    #2;
    sample_outputs();
  endtask

  task automatic walk_table(input bit bp, input bit blk);
    ar_q.delete();
    aw_q.delete();
    w_q.delete();
    cur       = 0;
    wbeat     = 0;
    pass_cyc  = 0;
    next_seen = 1'b0;
    bp_en     = bp;
    blk_en    = blk;
    hold_left = blk ? hold_len : 0;
    run_en    = 1'b1;
    rdy_mode  = bp ? 2 : 1;
    while (cur < n_cmds) begin
      cycle_step();
    end
    repeat (2) cycle_step();
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, err_cnt - errs_before);
    end
  endtask

  // ==============================
  // test sequence
  // ==============================
  initial begin
    int errs;
    int n_rd;
    int n_wr;
    int n_beats;
    void'($urandom(55));
    axi_rstn     = 1'b0;
    run          = 1'b0;
    rd_wait      = 1'b0;
    stats_clear  = 1'b0;
    arready      = 1'b0;
    awready      = 1'b0;
    wready       = 1'b0;
    cmd          = '0;
    wdata        = '0;
    wstrb        = '0;
    ar_pend_cnt  = '0;
    aw_pend_cnt  = '0;
    pend_max     = pend_lim;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    n_rd         = 0;
    n_wr         = 0;
    n_beats      = 0;
    load_table();
    cyc_limit = calc_limit();
    for (int i = 0; i < n_cmds; i++) begin
      if (tbl_cmd[i].is_read) begin
        n_rd++;
      end else begin
        n_wr++;
        n_beats += tbl_beats[i];
      end
    end
    repeat (5) @(posedge axi_clk);
    @(negedge axi_clk);
    axi_rstn = 1'b1;

    errs = err_cnt;
    walk_table(1'b0, 1'b0);
    finish_test("read and write issue", errs);

    errs = err_cnt;
    check_cnt("req_cnt", wide_w'(req_cnt), n_cmds);
    check_cnt("rd_cnt", wide_w'(rd_cnt), n_rd);
    check_cnt("wr_cnt", wide_w'(wr_cnt), n_wr);
    check_cnt("wbeat_cnt", wbeat_cnt, n_beats);
    clear_req = 1'b1;
    repeat (2) cycle_step();
    check_cnt("req_cnt", wide_w'(req_cnt), 0);
    check_cnt("rd_cnt", wide_w'(rd_cnt), 0);
    check_cnt("wr_cnt", wide_w'(wr_cnt), 0);
    check_cnt("wbeat_cnt", wbeat_cnt, 0);
    finish_test("statistics and clear", errs);

    errs = err_cnt;
    walk_table(1'b1, 1'b0);
    finish_test("random back-pressure", errs);

    errs = err_cnt;
    walk_table(1'b0, 1'b1);
    finish_test("pending limit and read wait", errs);

    // ready high, run low, a read then a write on offer
    errs      = err_cnt;
    pass_cyc  = 0;
    cur       = 0;
    hold_left = 0;
    rdy_mode  = 1;
    stop_chk  = 1'b1;
    repeat (10) cycle_step();
    cur = 1;
    repeat (10) cycle_step();
    stop_chk = 1'b0;
    finish_test("stop", errs);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+include
hw/mem_req_pkg.sv
hw/cmd_fetch.sv
hw/req_sequencer.sv
hw/req_stats.sv
hw/mem_req_gen.sv
dv/tb_mem_req_gen.sv

//--- run.sh
#!/bin/sh
# build and run the request generator testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_mem_req_gen -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "Regression passed" sim.log; then
  echo "simulation ok"
else
  echo "simulation not ok, see sim.log"
  exit 1
fi
